//--- mdu_data_pkg.sv
/* mdu_data_pkg
   datapath word width and the HI/LO result pair shared by the engines and registers */
package mdu_data_pkg;

    parameter int xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // divide: hi = remainder, lo = quotient
    // multiply: hi/lo = upper/lower product halves
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

endpackage

//--- mdu_op_pkg.sv
/* mdu_op_pkg
   operation encoding and request layout for the multiply/divide unit */
package mdu_op_pkg;

    import mdu_data_pkg::*;

    typedef enum logic [3:0] {
        op_mult  = 4'h0,   // signed multiply
        op_multu = 4'h1,
        op_div   = 4'h2,   // signed divide
        op_divu  = 4'h3,
        op_mthi  = 4'h4,   // move a into HI
        op_mtlo  = 4'h5,
        op_mfhi  = 4'h6,   // read HI out on rd_data
        op_mflo  = 4'h7,
        op_nop   = 4'h8
    } mdu_op_e;

    // one request from the core, 68 bits
    typedef struct packed {
        mdu_op_e op;
        word_t   a;    // dividend / multiplicand / move data
        word_t   b;    // divisor / multiplier
    } mdu_req_t;

endpackage

//--- div_radix2.sv
`timescale 1ns/1ps
/* div_radix2
   restoring radix-2 divider, WIDTH subtract-and-shift steps then a registered
   sign correction; result held under a valid/ready pair */
module div_radix2 #(
    parameter int WIDTH = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               opn_valid,  // one-way strobe, no ready
    input  logic [WIDTH-1:0]   a,          // dividend
    input  logic [WIDTH-1:0]   b,          // divisor
    input  logic               sign,
    output logic               res_valid,
    input  logic               res_ready,
    output logic [2*WIDTH-1:0] result      // {remainder, quotient}
);
    localparam int CW = $clog2(WIDTH);

    logic [2*WIDTH-1:0] sr;        // {partial remainder, dividend/quotient bits}
    logic [WIDTH+1:0]   neg_div;   // -|b|, two extra bits so b == 0 still subtracts
    logic               neg_rem;
    logic               neg_quo;
    logic               running;
    logic               finish;
    logic [CW-1:0]      cnt;

    logic               idle;
    logic               start;
    logic [WIDTH-1:0]   a_abs;
    logic [WIDTH-1:0]   b_abs;
    logic [WIDTH:0]     partial;
    logic [WIDTH+1:0]   diff;
    logic               ge;
    logic [WIDTH-1:0]   new_rem;
    logic [WIDTH-1:0]   rem;
    logic [WIDTH-1:0]   quo;

    assign idle  = ~running & ~finish & ~res_valid;
    assign start = idle & opn_valid;

    assign a_abs = (sign & a[WIDTH-1]) ? ~a + 1'b1 : a;
    assign b_abs = (sign & b[WIDTH-1]) ? ~b + 1'b1 : b;

    // shift in the next dividend bit and trial-subtract
    assign partial = {sr[2*WIDTH-1:WIDTH], sr[WIDTH-1]};
    assign diff    = {1'b0, partial} + neg_div;
    assign ge      = ~diff[WIDTH+1];   // non-negative difference, restore otherwise
    assign new_rem = ge ? diff[WIDTH-1:0] : partial[WIDTH-1:0];

    // remainder follows the dividend's sign
    assign rem = neg_rem ? ~sr[2*WIDTH-1:WIDTH] + 1'b1 : sr[2*WIDTH-1:WIDTH];
    assign quo = neg_quo ? ~sr[WIDTH-1:0] + 1'b1 : sr[WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            finish  <= 1'b0;
            cnt     <= '0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(WIDTH - 1)) begin   // last step
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sr      <= {{WIDTH{1'b0}}, a_abs};
            neg_div <= ~{2'b00, b_abs} + 1'b1;
            neg_rem <= sign & a[WIDTH-1];
            neg_quo <= sign & (a[WIDTH-1] ^ b[WIDTH-1]);
        end else if (running) begin
            sr <= {new_rem, sr[WIDTH-2:0], ge};
        end
        if (finish)
            result <= {rem, quo};
    end

    always_ff @(posedge clk) begin
        if (rst)
            res_valid <= 1'b0;
        else if (finish)
            res_valid <= 1'b1;
        else if (res_valid && res_ready)
            res_valid <= 1'b0;   // transferred
    end

endmodule

//--- mul_shift_add.sv
`timescale 1ns/1ps
/* mul_shift_add
   iterative shift-add multiplier on magnitudes, one multiplier bit per cycle,
   product negated afterwards for signed operands of opposite sign */
module mul_shift_add #(
    parameter int WIDTH = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               opn_valid,
    input  logic [WIDTH-1:0]   a,          // multiplicand
    input  logic [WIDTH-1:0]   b,          // multiplier
    input  logic               sign,
    output logic               res_valid,
    input  logic               res_ready,
    output logic [2*WIDTH-1:0] result      // {hi, lo}
);
    localparam int CW = $clog2(WIDTH);

    logic [2*WIDTH-1:0] mcand;   // shifts left each step
    logic [WIDTH-1:0]   mplr;    // lsb selects the add each step
    logic [2*WIDTH-1:0] acc;
    logic               neg;
    logic               running;
    logic               finish;
    logic [CW-1:0]      cnt;

    logic               idle;
    logic               start;
    logic [WIDTH-1:0]   a_abs;
    logic [WIDTH-1:0]   b_abs;
    logic [2*WIDTH-1:0] prod;

    assign idle  = ~running & ~finish & ~res_valid;
    assign start = idle & opn_valid;

    assign a_abs = (sign & a[WIDTH-1]) ? ~a + 1'b1 : a;
    assign b_abs = (sign & b[WIDTH-1]) ? ~b + 1'b1 : b;
    assign prod  = neg ? ~acc + 1'b1 : acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            finish  <= 1'b0;
            cnt     <= '0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(WIDTH - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    // operand capture and one shift-add step per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= {{WIDTH{1'b0}}, a_abs};
            mplr  <= b_abs;
            acc   <= '0;
            neg   <= sign & (a[WIDTH-1] ^ b[WIDTH-1]);
        end else if (running) begin
            if (mplr[0])
                acc <= acc + mcand;
            mcand <= mcand << 1;
            mplr  <= mplr >> 1;
        end
        if (finish)
            result <= prod;   // sign fix on the way out
    end

    always_ff @(posedge clk) begin
        if (rst)
            res_valid <= 1'b0;
        else if (finish)
            res_valid <= 1'b1;
        else if (res_valid && res_ready)
            res_valid <= 1'b0;
    end

endmodule

//--- hilo_regs.sv
`timescale 1ns/1ps
/* hilo_regs
   HI and LO result registers, each half written on its own enable */
module hilo_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_hi,
    input  logic                wr_lo,
    input  mdu_data_pkg::hilo_t wr_data,
    output mdu_data_pkg::hilo_t hilo
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hilo <= '0;   // reads after reset return zero
        end else begin
            if (wr_hi)
                hilo.hi <= wr_data.hi;
            if (wr_lo)
                hilo.lo <= wr_data.lo;
        end
    end

endmodule

//--- mdu_ctrl.sv
`timescale 1ns/1ps
/* mdu_ctrl
   op decode, engine dispatch and ownership, result port mux, HI/LO writes and reads */
module mdu_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  mdu_op_pkg::mdu_req_t req,
    input  logic                 req_valid,
    input  mdu_data_pkg::hilo_t  hilo,
    output logic                 mul_valid,
    output logic                 div_valid,
    output mdu_data_pkg::word_t  opn_a,
    output mdu_data_pkg::word_t  opn_b,
    output logic                 opn_sign,
    input  logic                 mul_res_valid,
    input  mdu_data_pkg::hilo_t  mul_result,
    input  logic                 div_res_valid,
    input  mdu_data_pkg::hilo_t  div_result,
    output logic                 mul_res_ready,
    output logic                 div_res_ready,
    output mdu_data_pkg::hilo_t  res,
    output logic                 res_valid,
    input  logic                 res_ready,
    output logic                 busy,
    output logic                 wr_hi,
    output logic                 wr_lo,
    output mdu_data_pkg::hilo_t  wr_data,
    output mdu_data_pkg::word_t  rd_data,
    output logic                 rd_valid
);
    import mdu_data_pkg::*;
    import mdu_op_pkg::*;

    typedef enum logic [1:0] {
        own_none,
        own_mul,
        own_div
    } owner_e;

    owner_e  owner;   // engine holding the current job
    mdu_op_e op;
    logic    is_mul;
    logic    is_div;
    logic    do_mthi;
    logic    do_mtlo;
    logic    do_mf;
    logic    xfer;
    word_t   rd_sel;

    assign op     = req.op;
    assign is_mul = (op == op_mult) || (op == op_multu);
    assign is_div = (op == op_div) || (op == op_divu);

    // arithmetic while busy is dropped here
    assign mul_valid = req_valid & is_mul & ~busy;
    assign div_valid = req_valid & is_div & ~busy;
    assign opn_a     = req.a;
    assign opn_b     = req.b;
    assign opn_sign  = (op == op_mult) || (op == op_div);

    always_ff @(posedge clk) begin
        if (rst)
            owner <= own_none;
        else if (xfer)
            owner <= own_none;
        else if (mul_valid)
            owner <= own_mul;
        else if (div_valid)
            owner <= own_div;
    end

    assign busy = (owner != own_none);

    always_comb begin
        res       = div_result;
        res_valid = 1'b0;
        case (owner)
            own_mul: begin
                res       = mul_result;
                res_valid = mul_res_valid;
            end
            own_div: begin
                res       = div_result;
                res_valid = div_res_valid;
            end
            default: ;
        endcase
    end

    assign xfer          = res_valid & res_ready;
    assign mul_res_ready = (owner == own_mul) & res_ready;
    assign div_res_ready = (owner == own_div) & res_ready;

    // a move in the same cycle as a transfer wins its half
    assign do_mthi    = req_valid & (op == op_mthi);
    assign do_mtlo    = req_valid & (op == op_mtlo);
    assign wr_hi      = xfer | do_mthi;
    assign wr_lo      = xfer | do_mtlo;
    assign wr_data.hi = do_mthi ? req.a : res.hi;
    assign wr_data.lo = do_mtlo ? req.a : res.lo;

    assign do_mf  = req_valid & ((op == op_mfhi) || (op == op_mflo));
    assign rd_sel = (op == op_mfhi) ? hilo.hi : hilo.lo;

    always_ff @(posedge clk) begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= do_mf;   // one-cycle pulse
    end

    always_ff @(posedge clk) begin
        if (do_mf)
            rd_data <= rd_sel;   // registers as they stood at acceptance
    end

endmodule

//--- mdu_top.sv
`timescale 1ns/1ps
/* mdu_top
   multiply/divide unit: controller, shift-add multiplier, radix-2 divider, HI/LO */
module mdu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  mdu_op_pkg::mdu_req_t req,
    input  logic                 req_valid,
    output mdu_data_pkg::hilo_t  res,
    output logic                 res_valid,
    input  logic                 res_ready,
    output logic                 busy,
    output mdu_data_pkg::word_t  rd_data,
    output logic                 rd_valid
);
    import mdu_data_pkg::*;

    logic  mul_valid;
    logic  div_valid;
    word_t opn_a;
    word_t opn_b;
    logic  opn_sign;
    logic  mul_res_valid;
    logic  div_res_valid;
    logic  mul_res_ready;
    logic  div_res_ready;
    hilo_t mul_result;
    hilo_t div_result;
    hilo_t hilo;
    hilo_t wr_data;
    logic  wr_hi;
    logic  wr_lo;

    mdu_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .hilo          (hilo),
        .mul_valid     (mul_valid),
        .div_valid     (div_valid),
        .opn_a         (opn_a),
        .opn_b         (opn_b),
        .opn_sign      (opn_sign),
        .mul_res_valid (mul_res_valid),
        .mul_result    (mul_result),
        .div_res_valid (div_res_valid),
        .div_result    (div_result),
        .mul_res_ready (mul_res_ready),
        .div_res_ready (div_res_ready),
        .res           (res),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .busy          (busy),
        .wr_hi         (wr_hi),
        .wr_lo         (wr_lo),
        .wr_data       (wr_data),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid)
    );

    mul_shift_add #(.WIDTH(xlen)) u_mul (
        .clk       (clk),
        .rst       (rst),
        .opn_valid (mul_valid),
        .a         (opn_a),
        .b         (opn_b),
        .sign      (opn_sign),
        .res_valid (mul_res_valid),
        .res_ready (mul_res_ready),
        .result    (mul_result)
    );

    div_radix2 #(.WIDTH(xlen)) u_div (
        .clk       (clk),
        .rst       (rst),
        .opn_valid (div_valid),
        .a         (opn_a),
        .b         (opn_b),
        .sign      (opn_sign),
        .res_valid (div_res_valid),
        .res_ready (div_res_ready),
        .result    (div_result)
    );

    hilo_regs u_hilo (
        .clk     (clk),
        .rst     (rst),
        .wr_hi   (wr_hi),
        .wr_lo   (wr_lo),
        .wr_data (wr_data),
        .hilo    (hilo)
    );

endmodule

//--- mdu_properties.sv
`timescale 1ns/1ps
/* mdu_properties
   busy, result-hold and latency rules of the multiply/divide unit, bound to mdu_top */
module mdu_properties (
    input logic                 clk,
    input logic                 rst,
    input mdu_op_pkg::mdu_req_t req,
    input logic                 req_valid,
    input mdu_data_pkg::hilo_t  res,
    input logic                 res_valid,
    input logic                 res_ready,
    input logic                 busy
);
    import mdu_op_pkg::*;

    logic arith;
    int   viol_count = 0;   // read by the testbench at the end of the run

    assign arith = (req.op == op_mult) || (req.op == op_multu) ||
                   (req.op == op_div) || (req.op == op_divu);

    // the core holds off multiply/divide while a job is open
    no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        req_valid && arith |-> !busy)
        else begin
            viol_count++;
            $error("multiply or divide request while busy");
        end

    // back-pressure only stretches the hold
    res_held: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else begin
            viol_count++;
            $error("result changed or dropped before transfer");
        end

    // rises after edge 33, first sampled high one edge later
    res_latency: assert property (@(posedge clk) disable iff (rst)
        req_valid && arith && !busy |-> ##34 $rose(res_valid))
        else begin
            viol_count++;
            $error("result valid not 33 cycles after accept");
        end

endmodule

bind mdu_top mdu_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .busy      (busy)
);

//--- tb_mdu.sv
`timescale 1ns/1ps
/* tb_mdu
   table-driven testbench for the multiply/divide unit, expected values from its
   own arithmetic rules and a private copy of HI/LO */
module tb_mdu;
    import mdu_data_pkg::*;
    import mdu_op_pkg::*;

    typedef struct {
        mdu_req_t req;
        hilo_t    exp;   // result pair or the read word in lo
    } row_t;

    logic     clk;
    logic     rst;
    mdu_req_t req;
    logic     req_valid;
    hilo_t    res;
    logic     res_valid;
    logic     res_ready;
    logic     busy;
    word_t    rd_data;
    logic     rd_valid;

    row_t  rows[$];
    word_t ref_hi;
    word_t ref_lo;
    int    seed;
    int    cycles;
    int    limit;

    mdu_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .busy      (busy),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("** Error: run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // HI/LO pair from the arithmetic rules
    function automatic hilo_t model_arith(input mdu_op_e code, input word_t x, input word_t y);
        logic [2*xlen-1:0] p;
        case (code)
            op_multu: p = {{xlen{1'b0}}, x} * {{xlen{1'b0}}, y};
            op_mult:  p = {{xlen{x[xlen-1]}}, x} * {{xlen{y[xlen-1]}}, y};
            op_divu: begin
                if (y == '0)
                    p = {x, {xlen{1'b1}}};   // all-ones quotient with the dividend kept
                else
                    p = {x % y, x / y};
            end
            default: p = {word_t'($signed(x) % $signed(y)), word_t'($signed(x) / $signed(y))};
        endcase
        return p;
    endfunction

    task automatic add_row(input mdu_op_e code, input word_t opa, input word_t opb);
        row_t row;
        row.req = '{op: code, a: opa, b: opb};
        row.exp = '0;
        case (code)
            op_mult, op_multu, op_div, op_divu: begin
                row.exp = model_arith(code, opa, opb);
                ref_hi  = row.exp.hi;
                ref_lo  = row.exp.lo;
            end
            op_mthi: ref_hi = opa;
            op_mtlo: ref_lo = opa;
            op_mfhi: row.exp.lo = ref_hi;
            op_mflo: row.exp.lo = ref_lo;
            default: ;
        endcase
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row(op_mfhi,  32'h0, 32'h0);   // zero after reset
        add_row(op_mflo,  32'h0, 32'h0);
        add_row(op_multu, 32'hffffffff, 32'hffffffff);
        add_row(op_mfhi,  32'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0);
        add_row(op_multu, 32'h12345678, 32'h9abcdef0);
        add_row(op_divu,  32'h00000064, 32'h00000007);
        add_row(op_mfhi,  32'h0, 32'h0);
        add_row(op_divu,  32'hdeadbeef, 32'h00000000);   // divide by zero
        add_row(op_mfhi,  32'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0);
        add_row(op_divu,  32'h00000005, 32'h00000010);
        add_row(op_mult,  32'h00000007, 32'h00000003);
        add_row(op_mult,  32'hfffffff9, 32'h00000003);
        add_row(op_mult,  32'h00000007, 32'hfffffffd);
        add_row(op_mult,  32'hfffffff9, 32'hfffffffd);
        add_row(op_mult,  32'h80000000, 32'h80000000);
        add_row(op_mult,  32'h7fffffff, 32'h80000000);
        add_row(op_div,   32'h00000064, 32'h00000007);
        add_row(op_div,   32'hffffff9c, 32'h00000007);
        add_row(op_div,   32'h00000064, 32'hfffffff9);
        add_row(op_div,   32'hffffff9c, 32'hfffffff9);
        add_row(op_mflo,  32'h0, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0);
        add_row(op_mthi,  32'hcafef00d, 32'h0);
        add_row(op_mtlo,  32'h0badf00d, 32'h0);
        add_row(op_mfhi,  32'h0, 32'h0);
        add_row(op_mflo,  32'h0, 32'h0);
        add_row(op_multu, 32'h00010001, 32'h0000ffff);
        add_row(op_mflo,  32'h0, 32'h0);
    endtask

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apply_arith(input row_t row);
        int waited;
        int hold;
        waited    = 0;
        req       = row.req;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        while (!res_valid) begin
            compare_values("busy", busy, 1);
            @(posedge clk);
            #1;
            waited++;
        end
        compare_values("res_valid latency", waited, 33);
        hold = {$random(seed)} % 4;   // back-pressure cycles
        repeat (hold) begin
            compare_values("res", res, row.exp);
            compare_values("busy", busy, 1);
            @(posedge clk);
            #1;
            compare_values("res_valid", res_valid, 1);
        end
        compare_values("res", res, row.exp);
        res_ready = 1'b1;
        @(posedge clk);
        #1;
        res_ready = 1'b0;
        compare_values("res_valid", res_valid, 0);
        compare_values("busy", busy, 0);
    endtask

    task automatic apply_hilo_op(input row_t row);
        req       = row.req;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (row.req.op == op_mfhi || row.req.op == op_mflo) begin
            compare_values("rd_valid", rd_valid, 1);
            compare_values("rd_data", rd_data, row.exp.lo);
            @(posedge clk);
            #1;
            compare_values("rd_valid", rd_valid, 0);   // single pulse
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '{op: op_nop, a: '0, b: '0};
        req_valid = 1'b0;
        res_ready = 1'b0;
        seed      = 91;
        cycles    = 0;
        ref_hi    = '0;
        ref_lo    = '0;
        build_table();
        limit = rows.size() * 40;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_values("busy", busy, 0);
        compare_values("res_valid", res_valid, 0);
        compare_values("rd_valid", rd_valid, 0);
        foreach (rows[i]) begin
            if (rows[i].req.op inside {op_mult, op_multu, op_div, op_divu})
                apply_arith(rows[i]);
            else
                apply_hilo_op(rows[i]);
        end
        @(posedge clk);
        #1;
        if (u_dut.u_props.viol_count != 0) begin
            $display("** Error: %0d assertion failures", u_dut.u_props.viol_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- tb.f
mdu_data_pkg.sv
mdu_op_pkg.sv
div_radix2.sv
mul_shift_add.sv
hilo_regs.sv
mdu_ctrl.sv
mdu_top.sv
mdu_properties.sv
tb_mdu.sv

//--- Makefile
# Verilator build and run of the multiply/divide unit testbench
TOP = tb_mdu

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
